// ==== design/icache_pkg.sv ====
/* shared data widths, AHB burst type codes and controller state encoding
   for the instruction cache core */

`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int XLEN = 32;  // instruction word and bus data width

  typedef logic [XLEN-1:0] word_t;  // one instruction / bus data word
  typedef logic [XLEN-1:0] addr_t;  // physical byte address

  //////////////////////////////////////////////////
  // bus burst types, AHB HBURST encoding

  localparam logic [2:0] BURST_SINGLE = 3'b000;
  localparam logic [2:0] BURST_WRAP4  = 3'b010;
  localparam logic [2:0] BURST_WRAP8  = 3'b100;
  localparam logic [2:0] BURST_WRAP16 = 3'b110;

  //////////////////////////////////////////////////
  // controller states

  // FLUSH    invalidate one set per cycle
  // ARMED    lookup, deliver hits, request on miss
  // FILL     burst in progress, forward critical word
  // REFETCH  re-read arrays once after the last word
  typedef enum logic [1:0] {
    FLUSH,
    ARMED,
    FILL,
    REFETCH
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/icache_way_select.sv ====
/* free-running LFSR and victim way choice, invalid ways first */

`timescale 1ns/1ps
`default_nettype none

module icache_way_select #(
  parameter int WAYS = 2
) (
  input  wire logic            clk,
  input  wire logic            rstn,
  input  wire logic            filling,
  input  wire logic [WAYS-1:0] way_valid,
  output logic [WAYS-1:0]      victim_way  // one-hot
);

  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic [19:0]     lfsr;
  logic [WAYS-1:0] invalid;
  logic [WAYS-1:0] rnd_way;
  logic [WAYS-1:0] pick;

  // xnor taps, so all zeros is a legal start
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) lfsr <= '0;
    else if (!filling) lfsr <= {lfsr[18:0], lfsr[19] ~^ lfsr[16]};
  end

  assign invalid = ~way_valid;
  assign rnd_way = WAYS'(1) << lfsr[WAY_BITS-1:0];
  assign pick    = (|invalid) ? (invalid & (~invalid + WAYS'(1)))  // lowest invalid
                              : rnd_way;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) victim_way <= WAYS'(1);
    else if (!filling) victim_way <= pick;  // frozen for the whole burst
  end

endmodule

`default_nettype wire

// ==== design/icache_tag_array.sv ====
/* valid and tag storage per set and way, set flush, fill tag write
   and the hit comparison against the fetch address */

`timescale 1ns/1ps
`default_nettype none

module icache_tag_array
  import icache_pkg::*;
#(
  parameter int  CACHE_KB    = 1,
  parameter int  BLOCK_BYTES = 16,
  parameter int  WAYS        = 2,
  localparam int SETS        = CACHE_KB * 1024 / BLOCK_BYTES / WAYS,
  localparam int IDX_BITS    = $clog2(SETS),
  localparam int WRD_BITS    = $clog2(BLOCK_BYTES / (XLEN / 8)),
  localparam int LKP_BITS    = IDX_BITS + WRD_BITS
) (
  input  wire logic                clk,
  input  wire logic [LKP_BITS-1:0] lookup_idx,
  input  wire addr_t               fetch_pc,
  input  wire logic                flushing,
  input  wire logic [IDX_BITS-1:0] flush_idx,
  input  wire logic                fill_done,
  input  wire logic [WAYS-1:0]     victim_way,
  input  wire addr_t               biu_adro,
  output logic                     hit,
  output logic [WAYS-1:0]          way_hit,
  output logic [WAYS-1:0]          way_valid
);

  localparam int OFF_BITS = $clog2(BLOCK_BYTES);
  localparam int TAG_BITS = XLEN - IDX_BITS - OFF_BITS;

  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;
  logic [TAG_BITS:0]   wr_entry;  // {valid, tag}
  logic [TAG_BITS-1:0] pc_tag;

  assign rd_idx = lookup_idx[WRD_BITS +: IDX_BITS];  // drop word bits
  assign wr_idx = flushing ? flush_idx : biu_adro[OFF_BITS +: IDX_BITS];
  assign pc_tag = fetch_pc[XLEN-1 -: TAG_BITS];

  // tag of the block being filled comes with the last returned word
  assign wr_entry = flushing ? '0 : {1'b1, biu_adro[XLEN-1 -: TAG_BITS]};

  //////////////////////////////////////////////////
  // one tag memory per way

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [TAG_BITS:0] mem [SETS];
    logic [TAG_BITS:0] rd_q;
    logic              we;

    assign we = flushing | (fill_done & victim_way[w]);  // flush hits all ways

    always_ff @(posedge clk) begin
      if (we) mem[wr_idx] <= wr_entry;
      // write-first on a collision, so the last flushed set reads clean
      if (we && (wr_idx == rd_idx)) rd_q <= wr_entry;
      else rd_q <= mem[rd_idx];
    end

    assign way_valid[w] = rd_q[TAG_BITS];
    assign way_hit[w]   = rd_q[TAG_BITS] & (rd_q[TAG_BITS-1:0] == pc_tag);
  end

  assign hit = |way_hit;

endmodule

`default_nettype wire

// ==== design/icache_data_array.sv ====
/* block storage per way with burst fill writes, synchronous word read
   and the hit-selected output mux with bus forwarding */

`timescale 1ns/1ps
`default_nettype none

module icache_data_array
  import icache_pkg::*;
#(
  parameter int  CACHE_KB    = 1,
  parameter int  BLOCK_BYTES = 16,
  parameter int  WAYS        = 2,
  localparam int SETS        = CACHE_KB * 1024 / BLOCK_BYTES / WAYS,
  localparam int IDX_BITS    = $clog2(SETS),
  localparam int WRD_BITS    = $clog2(BLOCK_BYTES / (XLEN / 8)),
  localparam int LKP_BITS    = IDX_BITS + WRD_BITS
) (
  input  wire logic                clk,
  input  wire logic [LKP_BITS-1:0] lookup_idx,
  input  wire logic                filling,
  input  wire logic [WAYS-1:0]     victim_way,
  input  wire logic                biu_rack,
  input  wire addr_t               biu_adro,
  input  wire word_t               biu_do,
  input  wire logic [WAYS-1:0]     way_hit,
  input  wire logic                fwd_sel,
  output word_t                    if_parcel
);

  localparam int BYTE_BITS = $clog2(XLEN / 8);
  localparam int DEPTH     = 1 << LKP_BITS;  // words per way

  logic [LKP_BITS-1:0] wr_adr;
  word_t               rd_q [WAYS];
  word_t               hit_data;

  assign wr_adr = biu_adro[BYTE_BITS +: LKP_BITS];  // {set, word in block}

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
      if (filling && victim_way[w] && biu_rack) mem[wr_adr] <= biu_do;
      rd_q[w] <= mem[lookup_idx];
    end
  end

  // at most one way hits, so an OR of masked words is the mux
  always_comb begin
    hit_data = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_data = hit_data | (rd_q[w] & {XLEN{way_hit[w]}});
    end
  end

  assign if_parcel = fwd_sel ? biu_do : hit_data;  // bus word during fill

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
/* instruction cache controller: fetch address register, state machine,
   shared flush/fill counter, hit/miss/forward decode and bus request */

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
#(
  parameter int    CACHE_KB    = 1,
  parameter int    BLOCK_BYTES = 16,
  parameter int    WAYS        = 2,
  parameter addr_t PC_INIT     = 32'h0000_0200,
  localparam int   SETS        = CACHE_KB * 1024 / BLOCK_BYTES / WAYS,
  localparam int   IDX_BITS    = $clog2(SETS),
  localparam int   WORDS       = BLOCK_BYTES / (XLEN / 8),
  localparam int   WRD_BITS    = $clog2(WORDS),
  localparam int   LKP_BITS    = IDX_BITS + WRD_BITS
) (
  input  wire logic                clk,
  input  wire logic                rstn,
  // fetch unit
  input  wire addr_t               if_nxt_pc,
  input  wire logic                if_stall,
  input  wire logic                if_flush,
  input  wire logic                bu_cacheflush,
  // from tag array
  input  wire logic                hit,
  // bus
  input  wire logic                biu_stb_ack,
  input  wire logic                biu_rack,
  input  wire addr_t               biu_adro,
  // to arrays
  output addr_t                    fetch_pc,
  output logic [LKP_BITS-1:0]      lookup_idx,
  output logic                     flushing,
  output logic                     filling,
  output logic                     fill_done,
  output logic [IDX_BITS-1:0]      flush_idx,
  // fetch unit
  output logic                     if_stall_nxt_pc,
  output addr_t                    if_parcel_pc,
  output logic                     if_parcel_valid,
  output logic                     fwd_sel,
  // bus
  output logic                     biu_stb,
  output addr_t                    biu_adri,
  output logic [2:0]               biu_type
);

  localparam int BYTE_BITS = $clog2(XLEN / 8);  // byte offset within a word
  localparam int CNT_BITS  = (IDX_BITS > WRD_BITS) ? IDX_BITS : WRD_BITS;

  ctrl_state_t         state, state_nxt;
  logic [CNT_BITS-1:0] cnt, cnt_nxt;  // sets in FLUSH, words in FILL
  logic                if_flush_dly;
  logic                hold_flush;  // cache flush seen outside FLUSH
  logic                flush_req;
  logic                blank;       // redirect window, no parcels
  logic                accept;
  logic                fwd;         // critical word on the bus now
  logic                cnt_zero;

  assign flush_req = bu_cacheflush | hold_flush;
  assign blank     = if_flush | if_flush_dly;
  assign accept    = if_flush | (~if_stall & ~if_stall_nxt_pc);
  assign cnt_zero  = ~|cnt;
  assign fwd       = biu_rack & ~blank &
                     (biu_adro[XLEN-1:BYTE_BITS] == fetch_pc[XLEN-1:BYTE_BITS]);

  //////////////////////////////////////////////////
  // fetch address and flags

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fetch_pc     <= PC_INIT;
      if_flush_dly <= 1'b0;
      hold_flush   <= 1'b0;
    end else begin
      if (accept) fetch_pc <= if_nxt_pc;  // redirect or next sequential
      if_flush_dly <= if_flush;
      hold_flush   <= ~flushing & flush_req;  // dropped once FLUSH starts
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= FLUSH;  // invalidate everything after reset
      cnt   <= CNT_BITS'(SETS - 1);
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  //////////////////////////////////////////////////
  // next state and fetch side decode

  always_comb begin
    state_nxt       = state;
    cnt_nxt         = cnt;
    biu_stb         = 1'b0;
    if_stall_nxt_pc = 1'b1;
    if_parcel_valid = 1'b0;
    fwd_sel         = 1'b0;
    fill_done       = 1'b0;
    case (state)
      FLUSH: begin
        if (cnt_zero) state_nxt = ARMED;  // last set cleared
        else cnt_nxt = cnt - 1'b1;
      end
      ARMED: begin
        if_parcel_valid = ~blank & hit;
        if_stall_nxt_pc = blank | ~hit;
        biu_stb         = ~blank & ~hit & ~flush_req;  // miss
        if (flush_req) begin
          state_nxt = FLUSH;
          cnt_nxt   = CNT_BITS'(SETS - 1);
        end else if (biu_stb && biu_stb_ack) begin
          state_nxt = FILL;
          cnt_nxt   = CNT_BITS'(WORDS - 1);
        end
      end
      FILL: begin
        if_parcel_valid = fwd;  // critical word straight from the bus
        if_stall_nxt_pc = ~fwd;
        fwd_sel         = fwd;
        if (flush_req) begin
          state_nxt = FLUSH;  // burst abandoned, tag never written
          cnt_nxt   = CNT_BITS'(SETS - 1);
        end else if (biu_rack) begin
          if (cnt_zero) begin
            fill_done = 1'b1;
            state_nxt = REFETCH;
          end else begin
            cnt_nxt = cnt - 1'b1;
          end
        end
      end
      REFETCH: state_nxt = ARMED;  // arrays re-read at fetch_pc
      default: state_nxt = FLUSH;
    endcase
  end

  assign flushing  = (state == FLUSH);
  assign filling   = (state == FILL);
  assign flush_idx = cnt[IDX_BITS-1:0];

  // new address only at the accepting edge
  assign lookup_idx = accept ? if_nxt_pc[BYTE_BITS +: LKP_BITS]
                             : fetch_pc[BYTE_BITS +: LKP_BITS];

  assign if_parcel_pc = fetch_pc;

  //////////////////////////////////////////////////
  // bus request

  assign biu_adri = {fetch_pc[XLEN-1:BYTE_BITS], {BYTE_BITS{1'b0}}};  // word aligned

  always_comb begin
    case (WORDS)
      4:       biu_type = BURST_WRAP4;
      8:       biu_type = BURST_WRAP8;
      16:      biu_type = BURST_WRAP16;
      default: biu_type = BURST_SINGLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
/* instruction cache top level, controller plus tag, data and
   victim select datapath */

`timescale 1ns/1ps
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int    CACHE_KB    = 1,        // capacity in KB
  parameter int    BLOCK_BYTES = 16,       // 16 to 64
  parameter int    WAYS        = 2,        // power of two
  parameter addr_t PC_INIT     = 32'h0000_0200
) (
  input  wire logic  clk,
  input  wire logic  rstn,
  // fetch unit
  input  wire addr_t if_nxt_pc,
  input  wire logic  if_stall,
  input  wire logic  if_flush,
  input  wire logic  bu_cacheflush,
  output logic       if_stall_nxt_pc,
  output addr_t      if_parcel_pc,
  output word_t      if_parcel,
  output logic       if_parcel_valid,
  // bus
  output logic       biu_stb,
  input  wire logic  biu_stb_ack,
  output addr_t      biu_adri,
  output logic [2:0] biu_type,
  input  wire logic  biu_rack,
  input  wire addr_t biu_adro,
  input  wire word_t biu_do
);

  localparam int SETS     = CACHE_KB * 1024 / BLOCK_BYTES / WAYS;
  localparam int IDX_BITS = $clog2(SETS);
  localparam int LKP_BITS = IDX_BITS + $clog2(BLOCK_BYTES / (XLEN / 8));

  addr_t               fetch_pc;
  logic [LKP_BITS-1:0] lookup_idx;  // set and word
  logic [IDX_BITS-1:0] flush_idx;
  logic                flushing;
  logic                filling;
  logic                fill_done;
  logic                fwd_sel;
  logic                hit;
  logic [WAYS-1:0]     way_hit;
  logic [WAYS-1:0]     way_valid;
  logic [WAYS-1:0]     victim_way;

  //////////////////////////////////////////////////
  // control

  icache_ctrl #(
    .CACHE_KB    (CACHE_KB),
    .BLOCK_BYTES (BLOCK_BYTES),
    .WAYS        (WAYS),
    .PC_INIT     (PC_INIT)
  ) ctrl_i (
    .clk             (clk),
    .rstn            (rstn),
    .if_nxt_pc       (if_nxt_pc),
    .if_stall        (if_stall),
    .if_flush        (if_flush),
    .bu_cacheflush   (bu_cacheflush),
    .hit             (hit),
    .biu_stb_ack     (biu_stb_ack),
    .biu_rack        (biu_rack),
    .biu_adro        (biu_adro),
    .fetch_pc        (fetch_pc),
    .lookup_idx      (lookup_idx),
    .flushing        (flushing),
    .filling         (filling),
    .fill_done       (fill_done),
    .flush_idx       (flush_idx),
    .if_stall_nxt_pc (if_stall_nxt_pc),
    .if_parcel_pc    (if_parcel_pc),
    .if_parcel_valid (if_parcel_valid),
    .fwd_sel         (fwd_sel),
    .biu_stb         (biu_stb),
    .biu_adri        (biu_adri),
    .biu_type        (biu_type)
  );

  //////////////////////////////////////////////////
  // datapath

  icache_tag_array #(
    .CACHE_KB    (CACHE_KB),
    .BLOCK_BYTES (BLOCK_BYTES),
    .WAYS        (WAYS)
  ) tag_i (
    .clk        (clk),
    .lookup_idx (lookup_idx),
    .fetch_pc   (fetch_pc),
    .flushing   (flushing),
    .flush_idx  (flush_idx),
    .fill_done  (fill_done),
    .victim_way (victim_way),
    .biu_adro   (biu_adro),
    .hit        (hit),
    .way_hit    (way_hit),
    .way_valid  (way_valid)
  );

  icache_data_array #(
    .CACHE_KB    (CACHE_KB),
    .BLOCK_BYTES (BLOCK_BYTES),
    .WAYS        (WAYS)
  ) data_i (
    .clk        (clk),
    .lookup_idx (lookup_idx),
    .filling    (filling),
    .victim_way (victim_way),
    .biu_rack   (biu_rack),
    .biu_adro   (biu_adro),
    .biu_do     (biu_do),
    .way_hit    (way_hit),
    .fwd_sel    (fwd_sel),
    .if_parcel  (if_parcel)
  );

  icache_way_select #(
    .WAYS (WAYS)
  ) way_sel_i (
    .clk        (clk),
    .rstn       (rstn),
    .filling    (filling),
    .way_valid  (way_valid),
    .victim_way (victim_way)
  );

endmodule

`default_nettype wire

// ==== bench/icache_checker.sv ====
/* concurrent protocol checks on the cache controller, bound into
   icache_ctrl */

`timescale 1ns/1ps
`default_nettype none

module icache_checker
  import icache_pkg::*;
(
  input wire logic        clk,
  input wire logic        rstn,
  input wire ctrl_state_t state,
  input wire logic        flushing,
  input wire logic        biu_stb,
  input wire logic        if_parcel_valid
);

  //////////////////////////////////////////////////
  // bus request

  // requests only come out of the lookup state
  stb_in_armed: assert property (@(posedge clk) disable iff (!rstn)
    biu_stb |-> (state == ARMED))
    else $error("bus request outside ARMED");

  stb_after_reset: assert property (@(posedge clk)
    !rstn |=> !biu_stb)
    else $error("bus request right after reset");

  //////////////////////////////////////////////////
  // fetch side

  no_parcel_flushing: assert property (@(posedge clk) disable iff (!rstn)
    !(if_parcel_valid && flushing))
    else $error("parcel valid during flush");

endmodule

bind icache_ctrl icache_checker checker_i (
  .clk             (clk),
  .rstn            (rstn),
  .state           (state),
  .flushing        (flushing),
  .biu_stb         (biu_stb),
  .if_parcel_valid (if_parcel_valid)
);

`default_nettype wire

// ==== bench/icache_tb.sv ====
/* testbench for the instruction cache: clock, reset, trace-driven fetch
   unit with random stall, wrapping burst bus model and parcel checks */

`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
;

  localparam int    CACHE_KB    = 1;
  localparam int    BLOCK_BYTES = 16;
  localparam int    WAYS        = 2;
  localparam addr_t PC_INIT     = 32'h0000_0200;
  localparam int    WORDS       = BLOCK_BYTES / 4;
  localparam int    MAX_ENT     = 64;
  localparam int    TIMEOUT     = 300;  // cycles, for every wait loop
  localparam int    WRONG       = -1;   // wrong-path fetch in flight
  localparam int    CMD_FETCH   = 0;
  localparam int    CMD_FLUSH   = 2;    // cache flush plus redirect

  logic       clk = 1'b0;
  logic       rstn;
  addr_t      if_nxt_pc;
  logic       if_stall;
  logic       if_flush;
  logic       bu_cacheflush;
  logic       if_stall_nxt_pc;
  addr_t      if_parcel_pc;
  word_t      if_parcel;
  logic       if_parcel_valid;
  logic       biu_stb;
  logic       biu_stb_ack = 1'b0;
  addr_t      biu_adri;
  logic [2:0] biu_type;
  logic       biu_rack = 1'b0;
  addr_t      biu_adro = '0;
  word_t      biu_do = '0;

  // trace columns
  int    tr_test [MAX_ENT];
  int    tr_cmd  [MAX_ENT];
  addr_t tr_addr [MAX_ENT];
  word_t tr_data [MAX_ENT];
  int    tr_miss [MAX_ENT];
  int    n_ent;

  int    seed = 80;
  int    req_count = 0;  // accepted bus requests
  int    miss_base = 0;  // req_count at the last delivery or redirect
  int    cur_ent = 0;    // trace entry the fetch unit waits for
  addr_t exp_adri;       // word address the next request must carry

  always #20 clk = ~clk;

  icache_top #(
    .CACHE_KB    (CACHE_KB),
    .BLOCK_BYTES (BLOCK_BYTES),
    .WAYS        (WAYS),
    .PC_INIT     (PC_INIT)
  ) dut_i (
    .clk             (clk),
    .rstn            (rstn),
    .if_nxt_pc       (if_nxt_pc),
    .if_stall        (if_stall),
    .if_flush        (if_flush),
    .bu_cacheflush   (bu_cacheflush),
    .if_stall_nxt_pc (if_stall_nxt_pc),
    .if_parcel_pc    (if_parcel_pc),
    .if_parcel       (if_parcel),
    .if_parcel_valid (if_parcel_valid),
    .biu_stb         (biu_stb),
    .biu_stb_ack     (biu_stb_ack),
    .biu_adri        (biu_adri),
    .biu_type        (biu_type),
    .biu_rack        (biu_rack),
    .biu_adro        (biu_adro),
    .biu_do          (biu_do)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input int k, input string what, input word_t exp_v,
                                 input word_t act_v);
    stop_on_error($sformatf("mismatch test %0d entry %0d %s: expected %h actual %h",
                            tr_test[k], k, what, exp_v, act_v));
  endtask

  //////////////////////////////////////////////////
  // bus model, wrapping burst with random gaps

  typedef enum int {B_IDLE, B_ACK, B_DATA} bus_state_t;

  bus_state_t bstate = B_IDLE;
  int         gap = 0;
  int         words_left = 0;
  addr_t      word_adr = '0;
  logic       s_stb = 1'b0;  // negedge samples
  addr_t      s_adri = '0;
  logic [2:0] s_type = '0;

  always @(negedge clk) begin
    s_stb  = biu_stb;
    s_adri = biu_adri;
    s_type = biu_type;
  end

  always @(posedge clk) begin
    biu_stb_ack <= 1'b0;
    biu_rack    <= 1'b0;
    if (!rstn) begin
      bstate <= B_IDLE;
    end else begin
      case (bstate)
        B_IDLE: if (s_stb) begin
          if (gap == 0) begin
            biu_stb_ack <= 1'b1;
            bstate      <= B_ACK;
          end else begin
            gap <= gap - 1;
          end
        end
        B_ACK: begin
          if (s_stb) begin  // still requesting in the ack cycle
            assert (s_type == BURST_WRAP4)
              else report_mismatch(cur_ent, "burst type", 32'(BURST_WRAP4), 32'(s_type));
            assert (s_adri == exp_adri)
              else report_mismatch(cur_ent, "burst address", exp_adri, s_adri);
            req_count  <= req_count + 1;
            word_adr   <= s_adri;
            words_left <= WORDS;
            gap        <= $unsigned($random(seed)) % 3;
            bstate     <= B_DATA;
          end else begin
            bstate <= B_IDLE;
          end
        end
        default: begin
          if (gap == 0) begin
            biu_rack   <= 1'b1;
            biu_adro   <= word_adr;
            biu_do     <= word_adr ^ 32'hC0DE_0000;  // memory contents
            // wrap inside the block
            word_adr   <= (word_adr & ~addr_t'(BLOCK_BYTES - 1)) |
                          ((word_adr + 32'd4) & addr_t'(BLOCK_BYTES - 1));
            words_left <= words_left - 1;
            gap        <= $unsigned($random(seed)) % 3;
            if (words_left == 1) bstate <= B_IDLE;
          end else begin
            gap <= gap - 1;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // fetch unit

  task automatic load_trace;
    int    fd;
    int    r;
    string line;
    n_ent = 0;
    fd = $fopen("bench/icache_trace.txt", "r");
    assert (fd != 0) else stop_on_error("trace file could not be opened");
    while (!$feof(fd) && n_ent < MAX_ENT) begin
      r = $fgets(line, fd);
      if (r > 0 && $sscanf(line, "%d %d %h %h %d", tr_test[n_ent], tr_cmd[n_ent],
                           tr_addr[n_ent], tr_data[n_ent], tr_miss[n_ent]) == 5) begin
        n_ent++;
      end
    end
    $fclose(fd);
    assert (n_ent > 1) else stop_on_error("trace file holds no commands");
  endtask

  task automatic check_parcel(input int k);
    int reqs;
    reqs      = req_count - miss_base;
    miss_base = req_count;
    assert (if_parcel_pc == tr_addr[k])
      else report_mismatch(k, "parcel pc", tr_addr[k], if_parcel_pc);
    assert (if_parcel == tr_data[k])
      else report_mismatch(k, "parcel", tr_data[k], if_parcel);
    assert (reqs == tr_miss[k])
      else report_mismatch(k, "bus requests", word_t'(tr_miss[k]), word_t'(reqs));
  endtask

  // hold off, let the wrong path settle, then redirect (and maybe flush)
  task automatic redirect_to(input int k);
    int waited;
    waited   = 0;
    if_stall <= 1'b1;
    do begin
      @(negedge clk);
      waited++;
      assert (waited < TIMEOUT) else stop_on_error("bus never went idle before a redirect");
    end while (biu_stb || bstate != B_IDLE);
    @(posedge clk);
    if_flush      <= 1'b1;
    if_nxt_pc     <= tr_addr[k];
    bu_cacheflush <= (tr_cmd[k] == CMD_FLUSH);
    if_stall      <= 1'b0;
    exp_adri       = tr_addr[k] & ~32'h3;
    @(negedge clk);  // old address must not come out
    assert (!if_parcel_valid)
      else stop_on_error("parcel delivered in the redirect cycle");
    @(posedge clk);
    if_flush      <= 1'b0;
    bu_cacheflush <= 1'b0;
    miss_base      = req_count;
    @(negedge clk);
    assert (!if_parcel_valid)
      else stop_on_error("parcel delivered in the cycle after a redirect");
    @(posedge clk);
  endtask

  task automatic run_trace;
    int    head;
    int    nxt;
    int    waited;
    bit    shown_fetch;
    addr_t shown;
    head   = 0;  // entry 0 is the reset address, fetched on its own
    nxt    = 1;
    waited = 0;
    while (head != WRONG || nxt < n_ent) begin
      if (head == WRONG) begin
        redirect_to(nxt);
        head   = nxt;
        nxt    = nxt + 1;
        waited = 0;
      end
      cur_ent     = head;
      shown_fetch = (nxt < n_ent) && (tr_cmd[nxt] == CMD_FETCH);
      shown       = shown_fetch ? tr_addr[nxt] : tr_addr[head] + 32'd4;  // else wrong path
      if_nxt_pc <= shown;
      if_stall  <= (($random(seed) & 32'sd3) == 32'sd0);
      @(negedge clk);
      waited++;
      assert (waited < TIMEOUT)
        else stop_on_error($sformatf("no parcel delivered for entry %0d", head));
      // next address taken exactly when a parcel is shown
      assert (if_stall_nxt_pc == !if_parcel_valid)
        else report_mismatch(head, "if_stall_nxt_pc", word_t'(!if_parcel_valid),
                             word_t'(if_stall_nxt_pc));
      if (if_parcel_valid && !if_stall) begin  // delivery, next address taken
        check_parcel(head);
        head     = shown_fetch ? nxt : WRONG;
        nxt      = shown_fetch ? nxt + 1 : nxt;
        exp_adri = shown & ~32'h3;
        waited   = 0;
      end
      @(posedge clk);
    end
  endtask

  initial begin
    rstn          = 1'b0;
    if_nxt_pc     = '0;
    if_stall      = 1'b0;
    if_flush      = 1'b0;
    bu_cacheflush = 1'b0;
    exp_adri      = PC_INIT;
    load_trace();
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    run_trace();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/icache_trace.txt ====
# columns: test cmd address expected_parcel bus_requests
# cmd 0 fetch, 1 redirect, 2 cache flush with redirect; entry 0 is the reset address
1 0 00000200 c0de0200 1
2 0 00000204 c0de0204 0
2 0 0000020c c0de020c 0
2 0 00000208 c0de0208 0
# same set, second way
3 0 00000400 c0de0400 1
3 0 00000404 c0de0404 0
3 0 00000200 c0de0200 0
3 0 00000408 c0de0408 0
3 0 0000020c c0de020c 0
3 0 0000040c c0de040c 0
6 0 00000210 c0de0210 1
6 0 00000214 c0de0214 0
6 0 0000021c c0de021c 0
6 0 00000218 c0de0218 0
# redirect away from the wrong path
5 1 0000031c c0de031c 1
5 0 00000310 c0de0310 0
5 0 00000314 c0de0314 0
6 0 00000820 c0de0820 1
6 0 00000824 c0de0824 0
6 0 0000082c c0de082c 0
6 0 00000828 c0de0828 0
6 0 00000830 c0de0830 1
6 0 00000834 c0de0834 0
6 0 00000210 c0de0210 0
6 0 00000404 c0de0404 0
5 1 00000214 c0de0214 0
# cache flush, resident blocks miss again
4 2 00000200 c0de0200 1
4 0 00000204 c0de0204 0
4 0 00000400 c0de0400 1
4 0 00000210 c0de0210 1
4 0 00000200 c0de0200 0
4 0 00000404 c0de0404 0

// ==== icache.f ====
design/icache_pkg.sv
design/icache_way_select.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_ctrl.sv
design/icache_top.sv
bench/icache_checker.sv
bench/icache_tb.sv

// ==== Makefile ====
SOURCES := $(shell cat icache.f)

obj_dir/Vicache_tb: icache.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
		-f icache.f -o Vicache_tb

run: obj_dir/Vicache_tb
	./obj_dir/Vicache_tb 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
